//--- Makefile
TOP = tbRvSoc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
verilog/rvIsaPkg.sv
verilog/coreBusPkg.sv
verilog/alu.sv
verilog/instrDecoder.sv
verilog/coreControl.sv
verilog/busArbiter.sv
verilog/apbRam.sv
verilog/rvSoc.sv
testbench/tbRvSoc.sv

//--- testbench/tbRvSoc.sv
module tbRvSoc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MemWords = 256;
  localparam int TimeoutCycles = 4000;
  localparam logic [31:0] DataBase = 32'h200;
  localparam logic [31:0] ResBase = 32'h300;

  logic               clk;
  logic               arstN;
  logic               run;
  coreBusPkg::apbReqT hostReq;
  coreBusPkg::apbRspT hostRsp;
  logic               halted;
  logic               busy;

  logic [15:0]    lfsr;
  rvIsaPkg::wordT prog [16];
  rvIsaPkg::wordT expVal [5];
  int             progLen;
  int             checks;
  int             errors;
  int             runCycles;
  int             cycles = 0;

  rvSoc #(.MemWords(MemWords)) uut (
    .clk(clk), .arstN(arstN), .run(run), .hostReq(hostReq),
    .hostRsp(hostRsp), .halted(halted), .busy(busy)
  );

  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic rvIsaPkg::wordT randBits(int n);
    rvIsaPkg::wordT r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rvIsaPkg::wordT encR(rvIsaPkg::funct7T f7, rvIsaPkg::funct3T f3,
                                          int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rvIsaPkg::OpAlu};
  endfunction

  function automatic rvIsaPkg::wordT encI(rvIsaPkg::funct3T f3, int rd, int rs1,
                                          logic [31:0] imm, rvIsaPkg::opcodeT op);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic rvIsaPkg::wordT encS(int rs2, int rs1, logic [31:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rvIsaPkg::OpStore};
  endfunction

  function automatic rvIsaPkg::wordT encB(rvIsaPkg::funct3T f3, int rs1, int rs2,
                                          logic [31:0] imm);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], rvIsaPkg::OpBranch};
  endfunction

  function automatic rvIsaPkg::wordT encU(rvIsaPkg::opcodeT op, int rd, logic [31:0] imm);
    return {imm[19:0], 5'(rd), op};
  endfunction

  function automatic rvIsaPkg::wordT encJ(int rd, logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rvIsaPkg::OpJump};
  endfunction

  function automatic void emit(rvIsaPkg::wordT instr);
    prog[progLen] = instr;
    progLen++;
  endfunction

  task automatic checkWord(string name, rvIsaPkg::wordT exp, rvIsaPkg::wordT act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkTrue(logic cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic hostWrite(rvIsaPkg::wordT addr, rvIsaPkg::wordT data);
    @(posedge clk);
    hostReq <= '{sel: 1'b1, enable: 1'b0, write: 1'b1,
                 addr: coreBusPkg::addrT'(addr), wdata: data};
    @(posedge clk);
    hostReq.enable <= 1'b1;
    do @(negedge clk); while (!hostRsp.ready);  // may wait behind the core
    @(posedge clk);
    hostReq <= '0;
  endtask

  task automatic hostRead(rvIsaPkg::wordT addr, output rvIsaPkg::wordT data);
    @(posedge clk);
    hostReq <= '{sel: 1'b1, enable: 1'b0, write: 1'b0,
                 addr: coreBusPkg::addrT'(addr), wdata: '0};
    @(posedge clk);
    hostReq.enable <= 1'b1;
    do @(negedge clk); while (!hostRsp.ready);
    data = hostRsp.rdata;
    @(posedge clk);
    hostReq <= '0;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progLen; i++) hostWrite(32'(4 * i), prog[i]);
  endtask

  task automatic runProgram();
    logic sawBusy;
    sawBusy   = 1'b0;
    runCycles = 0;
    @(posedge clk);
    run <= 1'b1;
    do begin
      @(negedge clk);
      runCycles++;
      sawBusy = sawBusy | busy;
    end while (!halted);
    checkTrue(sawBusy, "busy never rose while the program ran");
    @(posedge clk);
    run <= 1'b0;
    do @(negedge clk); while (halted);  // back to idle, PC 0
  endtask

  task automatic checkResults(string test, int n);
    rvIsaPkg::wordT got;
    for (int k = 0; k < n; k++) begin
      hostRead(ResBase + 4 * k, got);
      checkWord($sformatf("%s[%0d]", test, k), expVal[k], got);
    end
  endtask

  task automatic memPortTest();
    rvIsaPkg::wordT addr;
    rvIsaPkg::wordT data;
    rvIsaPkg::wordT got;
    checkTrue(!halted && !busy, "halted or busy is set after reset");
    repeat (6) begin
      addr = randBits(8) << 2;
      data = randBits(32);
      hostWrite(addr, data);
      hostRead(addr, got);
      checkWord("memPort", data, got);
    end
  endtask

  task automatic regOpsTest();
    rvIsaPkg::wordT a;
    rvIsaPkg::wordT b;
    a = randBits(32);
    b = randBits(32);
    hostWrite(DataBase, a);
    hostWrite(DataBase + 4, b);
    progLen = 0;
    emit(encI(3'b010, 1, 0, DataBase, rvIsaPkg::OpLoad));
    emit(encI(3'b010, 2, 0, DataBase + 4, rvIsaPkg::OpLoad));
    emit(encR(rvIsaPkg::Funct7AddOrAnd, rvIsaPkg::Funct3Add, 3, 1, 2));
    emit(encR(rvIsaPkg::Funct7Sub, rvIsaPkg::Funct3Add, 4, 1, 2));
    emit(encR(rvIsaPkg::Funct7Mul, rvIsaPkg::Funct3Add, 5, 1, 2));
    emit(encR(rvIsaPkg::Funct7AddOrAnd, rvIsaPkg::Funct3Or, 6, 1, 2));
    emit(encR(rvIsaPkg::Funct7AddOrAnd, rvIsaPkg::Funct3And, 7, 1, 2));
    for (int r = 3; r <= 7; r++) emit(encS(r, 0, ResBase + 4 * (r - 3)));
    emit('0);
    loadProgram();
    runProgram();
    expVal[0] = a + b;
    expVal[1] = a - b;
    expVal[2] = a * b;  // low word
    expVal[3] = a | b;
    expVal[4] = a & b;
    checkResults("regOps", 5);
  endtask

  task automatic immOpsTest();
    rvIsaPkg::wordT a;
    rvIsaPkg::wordT imm;
    rvIsaPkg::wordT sh1;
    rvIsaPkg::wordT sh2;
    rvIsaPkg::wordT u1;
    rvIsaPkg::wordT u2;
    a   = randBits(32);
    imm = randBits(12);
    sh1 = randBits(5);
    sh2 = randBits(5);
    u1  = randBits(20);
    u2  = randBits(20);
    hostWrite(DataBase, a);
    progLen = 0;
    emit(encI(3'b010, 1, 0, DataBase, rvIsaPkg::OpLoad));
    emit(encI(rvIsaPkg::Funct3Addi, 2, 1, imm, rvIsaPkg::OpAluImm));
    emit(encI(rvIsaPkg::Funct3Slli, 3, 1, sh1, rvIsaPkg::OpAluImm));
    emit(encI(rvIsaPkg::Funct3Srli, 4, 1, sh2, rvIsaPkg::OpAluImm));
    emit(encU(rvIsaPkg::OpLui, 5, u1));
    emit(encU(rvIsaPkg::OpAuipc, 6, u2));  // sits at PC 20
    for (int r = 2; r <= 6; r++) emit(encS(r, 0, ResBase + 4 * (r - 2)));
    emit('0);
    loadProgram();
    runProgram();
    expVal[0] = a + {{20{imm[11]}}, imm[11:0]};
    expVal[1] = a << sh1;
    expVal[2] = a >> sh2;
    expVal[3] = {u1[19:0], 12'b0};
    expVal[4] = 32'd20 + {u2[19:0], 12'b0};
    checkResults("immOps", 5);
  endtask

  task automatic branchTest();
    rvIsaPkg::funct3T br [4] = '{rvIsaPkg::Funct3Beq, rvIsaPkg::Funct3Bne,
                                 rvIsaPkg::Funct3Bge, rvIsaPkg::Funct3Blt};
    string            brName [4] = '{"beq", "bne", "bge", "blt"};
    rvIsaPkg::wordT   pairA [3];
    rvIsaPkg::wordT   pairB [3];
    rvIsaPkg::wordT   x;
    rvIsaPkg::wordT   got;
    logic             taken;
    x = randBits(31);
    pairA = '{x, x, x | 32'h8000_0000};  // equal, lower, higher
    pairB = '{x, x | 32'h8000_0000, x};
    progLen = 0;
    emit(encI(3'b010, 1, 0, DataBase, rvIsaPkg::OpLoad));
    emit(encI(3'b010, 2, 0, DataBase + 4, rvIsaPkg::OpLoad));
    emit('0);  // branch slot at PC 8
    emit(encI(rvIsaPkg::Funct3Addi, 3, 0, 1, rvIsaPkg::OpAluImm));
    emit(encJ(0, 8));
    emit(encI(rvIsaPkg::Funct3Addi, 3, 0, 2, rvIsaPkg::OpAluImm));
    emit(encS(3, 0, ResBase));
    emit('0);
    loadProgram();
    for (int f = 0; f < 4; f++) begin
      for (int p = 0; p < 3; p++) begin
        hostWrite(8, encB(br[f], 1, 2, 12));
        hostWrite(DataBase, pairA[p]);
        hostWrite(DataBase + 4, pairB[p]);
        hostWrite(ResBase, 0);
        runProgram();
        taken = (f == 0) ? (pairA[p] == pairB[p]) : (f == 1) ? (pairA[p] != pairB[p]) :
                (f == 2) ? (pairA[p] >= pairB[p]) : (pairA[p] < pairB[p]);
        hostRead(ResBase, got);
        checkWord($sformatf("branch %s pair %0d", brName[f], p), taken ? 2 : 1, got);
      end
    end
    progLen = 0;
    emit(encI(rvIsaPkg::Funct3Addi, 2, 0, 7, rvIsaPkg::OpAluImm));
    emit(encJ(1, 8));                // PC 4, lands on PC 12
    emit(encS(2, 0, ResBase + 4));   // skipped
    emit(encS(1, 0, ResBase + 8));
    emit('0);
    hostWrite(ResBase + 4, 0);
    loadProgram();
    runProgram();
    hostRead(ResBase + 4, got);
    checkWord("jal skipped store", 0, got);
    hostRead(ResBase + 8, got);
    checkWord("jal link", 8, got);
  endtask

  task automatic contentionTest();
    rvIsaPkg::wordT     n;
    rvIsaPkg::wordT     got;
    rvIsaPkg::wordT     sumQuiet;
    rvIsaPkg::wordT     zeroQuiet;
    int                 quietCycles;
    logic               running;
    coreBusPkg::masterT reader;
    reader = coreBusPkg::MstHost;
    n = randBits(3) + 4;
    hostWrite(DataBase, n);
    progLen = 0;
    emit(encI(3'b010, 1, 0, DataBase, rvIsaPkg::OpLoad));
    emit(encI(rvIsaPkg::Funct3Addi, 2, 0, 0, rvIsaPkg::OpAluImm));
    emit(encR(rvIsaPkg::Funct7AddOrAnd, rvIsaPkg::Funct3Add, 2, 2, 1));
    emit(encI(rvIsaPkg::Funct3Addi, 1, 1, 32'hFFFF_FFFF, rvIsaPkg::OpAluImm));
    emit(encB(rvIsaPkg::Funct3Bne, 1, 0, 32'hFFFF_FFF8));  // back to the ADD
    emit(encI(rvIsaPkg::Funct3Addi, 0, 2, 5, rvIsaPkg::OpAluImm));  // x0 stays zero
    emit(encS(2, 0, ResBase));
    emit(encS(0, 0, ResBase + 4));
    emit('0);
    loadProgram();
    runProgram();
    quietCycles = runCycles;
    hostRead(ResBase, sumQuiet);
    hostRead(ResBase + 4, zeroQuiet);
    checkWord("loop sum", n * (n + 1) / 2, sumQuiet);
    checkWord("x0 read", 0, zeroQuiet);
    hostWrite(ResBase, 0);
    hostWrite(ResBase + 4, 32'hFFFF_FFFF);
    running = 1'b1;
    fork
      begin
        runProgram();
        running = 1'b0;
      end
      while (running) begin
        hostRead(DataBase, got);
        checkWord($sformatf("%s read under contention", reader.name()), n, got);
      end
    join
    checkTrue(runCycles > quietCycles, "the host reads did not stall the core");
    hostRead(ResBase, got);
    checkWord("loop sum under contention", sumQuiet, got);
    hostRead(ResBase + 4, got);
    checkWord("x0 read under contention", zeroQuiet, got);
  endtask

  initial begin
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk     = 1'b0;
    arstN   = 1'b0;
    run     = 1'b0;
    hostReq = '0;
    lfsr    = 16'd44;
    checks  = 0;
    errors  = 0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    memPortTest();
    regOpsTest();
    immOpsTest();
    branchTest();
    contentionTest();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/alu.sv
module alu (
  input  rvIsaPkg::wordT    pc,
  input  rvIsaPkg::decodedT dec,
  input  rvIsaPkg::wordT    aluIn1,
  input  rvIsaPkg::wordT    aluIn2,
  output rvIsaPkg::wordT    aluOut,
  output rvIsaPkg::wordT    newPc,
  output logic              branchTaken
);

  rvIsaPkg::wordT aluAdd;
  rvIsaPkg::wordT aluSub;
  rvIsaPkg::wordT aluMul;

  assign aluAdd = aluIn1 + aluIn2;
  assign aluSub = aluIn1 - aluIn2;
  assign aluMul = aluIn1 * aluIn2;  // low word only
  assign newPc  = pc + dec.imm;     // branch/jump target, also AUIPC

  always_comb begin
    aluOut      = '0;
    branchTaken = 1'b0;
    case (dec.opcode)
      rvIsaPkg::OpAlu: begin
        case (dec.funct7)
          rvIsaPkg::Funct7Sub: aluOut = aluSub;
          rvIsaPkg::Funct7Mul: aluOut = aluMul;
          rvIsaPkg::Funct7AddOrAnd: begin
            case (dec.funct3)
              rvIsaPkg::Funct3Add: aluOut = aluAdd;
              rvIsaPkg::Funct3Or:  aluOut = aluIn1 | aluIn2;
              rvIsaPkg::Funct3And: aluOut = aluIn1 & aluIn2;
              default:             aluOut = '0;
            endcase
          end
          default: aluOut = '0;
        endcase
      end
      rvIsaPkg::OpAluImm: begin
        case (dec.funct3)
          rvIsaPkg::Funct3Addi: aluOut = aluIn1 + dec.imm;
          rvIsaPkg::Funct3Slli: aluOut = aluIn1 << aluIn2[4:0];  // aluIn2 holds shamt
          rvIsaPkg::Funct3Srli: aluOut = aluIn1 >> aluIn2[4:0];
          default:              aluOut = '0;
        endcase
      end
      rvIsaPkg::OpLui:   aluOut = dec.imm;
      rvIsaPkg::OpAuipc: aluOut = newPc;
      rvIsaPkg::OpBranch: begin
        // unsigned compares only
        case (dec.funct3)
          rvIsaPkg::Funct3Beq: branchTaken = (aluSub == '0);
          rvIsaPkg::Funct3Bne: branchTaken = (aluSub != '0);
          rvIsaPkg::Funct3Bge: branchTaken = (aluIn1 >= aluIn2);
          rvIsaPkg::Funct3Blt: branchTaken = (aluIn1 < aluIn2);
          default:             branchTaken = 1'b0;
        endcase
      end
      rvIsaPkg::OpJump:  branchTaken = 1'b1;
      rvIsaPkg::OpLoad:  aluOut = aluIn1 + dec.imm;
      rvIsaPkg::OpStore: aluOut = aluIn1 + dec.imm;
      default:           aluOut = '0;
    endcase
  end

endmodule

//--- verilog/apbRam.sv
module apbRam #(
  parameter int MemWords = 256
) (
  input  logic               clk,
  input  logic               arstN,
  input  coreBusPkg::apbReqT req,
  output coreBusPkg::apbRspT rsp
);

  localparam int IdxW = $clog2(MemWords);

  rvIsaPkg::wordT  mem [MemWords];
  logic [IdxW-1:0] wordIdx;
  logic            setup;

  assign wordIdx = req.addr[IdxW+1:2];  // word addressed
  assign setup   = req.sel & ~req.enable;

  // read data is ready for the access phase
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rsp <= '0;
    end else begin
      rsp.ready <= setup;
      if (setup) rsp.rdata <= mem[wordIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (req.sel && req.enable && rsp.ready && req.write) mem[wordIdx] <= req.wdata;
  end

endmodule

//--- verilog/busArbiter.sv
module busArbiter (
  input  logic               clk,
  input  logic               arstN,
  input  coreBusPkg::apbReqT hostReq,
  input  coreBusPkg::apbReqT coreReq,
  input  coreBusPkg::apbRspT ramRsp,
  output coreBusPkg::apbRspT hostRsp,
  output coreBusPkg::apbRspT coreRsp,
  output coreBusPkg::apbReqT ramReq
);

  coreBusPkg::masterT owner;
  coreBusPkg::masterT grant;
  logic               grantedLast;  // bus held since the previous cycle
  logic               complete;

  // host wins over core when the bus is free
  always_comb begin
    if (grantedLast)      grant = owner;
    else if (hostReq.sel) grant = coreBusPkg::MstHost;
    else if (coreReq.sel) grant = coreBusPkg::MstCore;
    else                  grant = coreBusPkg::MstNone;
  end

  always_comb begin
    case (grant)
      coreBusPkg::MstHost: ramReq = hostReq;
      coreBusPkg::MstCore: ramReq = coreReq;
      default:             ramReq = '0;
    endcase
    // grant cycle is always a setup cycle at the RAM
    ramReq.enable = ramReq.enable & grantedLast;
  end

  assign complete = ramReq.sel & ramReq.enable & ramRsp.ready;

  assign hostRsp.rdata = ramRsp.rdata;
  assign hostRsp.ready = complete && (grant == coreBusPkg::MstHost);
  assign coreRsp.rdata = ramRsp.rdata;
  assign coreRsp.ready = complete && (grant == coreBusPkg::MstCore);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      owner       <= coreBusPkg::MstNone;
      grantedLast <= 1'b0;
    end else begin
      owner       <= grant;
      grantedLast <= (grant != coreBusPkg::MstNone) && !complete;  // release after completion
    end
  end

endmodule

//--- verilog/coreBusPkg.sv
package coreBusPkg;

  // byte address, low two bits ignored by the RAM
  typedef logic [9:0] addrT;

  typedef struct packed {
    logic           sel;
    logic           enable;
    logic           write;
    addrT           addr;
    rvIsaPkg::wordT wdata;
  } apbReqT;

  typedef struct packed {
    rvIsaPkg::wordT rdata;
    logic           ready;
  } apbRspT;

  typedef enum logic [1:0] {
    MstNone,
    MstHost,
    MstCore
  } masterT;

endpackage

//--- verilog/coreControl.sv
module coreControl (
  input  logic               clk,
  input  logic               arstN,
  input  logic               run,
  input  coreBusPkg::apbRspT busRsp,
  output coreBusPkg::apbReqT busReq,
  output logic               halted,
  output logic               busy
);

  typedef enum logic [2:0] {Idle, Fetch, Execute, Mem, Halt} stateT;

  stateT             state;
  logic              accessPhase;  // set once the setup cycle has been sent
  rvIsaPkg::wordT    pc;
  rvIsaPkg::wordT    ir;
  rvIsaPkg::wordT    regFile [32];
  rvIsaPkg::decodedT dec;
  rvIsaPkg::wordT    rs1Val;
  rvIsaPkg::wordT    rs2Val;
  rvIsaPkg::wordT    aluIn2;
  rvIsaPkg::wordT    aluOut;
  rvIsaPkg::wordT    newPc;
  rvIsaPkg::wordT    pcPlus4;
  rvIsaPkg::wordT    rdData;
  logic              branchTaken;
  logic              busDone;
  logic              rdWrite;
  logic              isMemOp;

  instrDecoder decoder (.instr(ir), .dec(dec));

  alu aluUnit (
    .pc(pc), .dec(dec), .aluIn1(rs1Val), .aluIn2(aluIn2),
    .aluOut(aluOut), .newPc(newPc), .branchTaken(branchTaken)
  );

  assign rs1Val  = (dec.rs1 == '0) ? '0 : regFile[dec.rs1];  // x0 reads zero
  assign rs2Val  = (dec.rs2 == '0) ? '0 : regFile[dec.rs2];
  assign aluIn2  = (dec.opcode == rvIsaPkg::OpAluImm) ? dec.imm : rs2Val;
  assign pcPlus4 = pc + 32'd4;
  assign busDone = busReq.sel & busReq.enable & busRsp.ready;
  assign isMemOp = (dec.opcode == rvIsaPkg::OpLoad) || (dec.opcode == rvIsaPkg::OpStore);
  assign halted  = (state == Halt);
  assign busy    = (state == Fetch) || (state == Execute) || (state == Mem);

  always_comb begin
    busReq        = '0;
    busReq.addr   = (state == Mem) ? coreBusPkg::addrT'(aluOut) : coreBusPkg::addrT'(pc);
    busReq.wdata  = rs2Val;
    if (state == Fetch || state == Mem) begin
      busReq.sel    = 1'b1;
      busReq.enable = accessPhase;
      busReq.write  = (state == Mem) && (dec.opcode == rvIsaPkg::OpStore);
    end
  end

  // writeback at end of Execute, loads at end of Mem
  always_comb begin
    rdWrite = 1'b0;
    rdData  = aluOut;
    if (state == Execute) begin
      case (dec.opcode)
        rvIsaPkg::OpAlu, rvIsaPkg::OpAluImm, rvIsaPkg::OpLui, rvIsaPkg::OpAuipc: rdWrite = 1'b1;
        rvIsaPkg::OpJump: begin
          rdWrite = 1'b1;
          rdData  = pcPlus4;  // link value
        end
        default: rdWrite = 1'b0;
      endcase
    end else if (state == Mem && busDone && dec.opcode == rvIsaPkg::OpLoad) begin
      rdWrite = 1'b1;
      rdData  = busRsp.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rdWrite && dec.rd != '0) regFile[dec.rd] <= rdData;
    if (state == Fetch && busDone) ir <= busRsp.rdata;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= Idle;
      accessPhase <= 1'b0;
      pc          <= '0;
    end else begin
      case (state)
        Idle: if (run) state <= Fetch;
        Fetch, Mem: begin
          accessPhase <= ~busDone;
          if (busDone) state <= (state == Fetch) ? Execute : Fetch;
        end
        Execute: begin
          if (dec.opcode == rvIsaPkg::OpHalt) begin
            state <= Halt;
          end else begin
            pc    <= branchTaken ? newPc : pcPlus4;
            state <= isMemOp ? Mem : Fetch;
          end
        end
        Halt: begin
          if (!run) begin
            state <= Idle;
            pc    <= '0;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

//--- verilog/instrDecoder.sv
module instrDecoder (
  input  rvIsaPkg::wordT    instr,
  output rvIsaPkg::decodedT dec
);

  always_comb begin
    dec.opcode = rvIsaPkg::opcodeT'(instr[6:0]);
    dec.rd     = instr[11:7];
    dec.funct3 = instr[14:12];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.funct7 = instr[31:25];

    case (dec.opcode)
      rvIsaPkg::OpAluImm: begin
        if (dec.funct3 == rvIsaPkg::Funct3Slli || dec.funct3 == rvIsaPkg::Funct3Srli) begin
          dec.imm = {27'b0, instr[24:20]};  // shift amount
        end else begin
          dec.imm = {{20{instr[31]}}, instr[31:20]};
        end
      end
      rvIsaPkg::OpLoad:  dec.imm = {{20{instr[31]}}, instr[31:20]};
      rvIsaPkg::OpStore: dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rvIsaPkg::OpBranch: begin
        dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rvIsaPkg::OpLui, rvIsaPkg::OpAuipc: dec.imm = {instr[31:12], 12'b0};
      rvIsaPkg::OpJump: begin
        dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: dec.imm = '0;
    endcase
  end

endmodule

//--- verilog/rvIsaPkg.sv
package rvIsaPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;
  typedef logic [2:0]  funct3T;
  typedef logic [6:0]  funct7T;

  // an all-zero opcode field stops the core
  typedef enum logic [6:0] {
    OpHalt   = 7'b0000000,
    OpAlu    = 7'b0110011,
    OpAluImm = 7'b0010011,
    OpLui    = 7'b0110111,
    OpAuipc  = 7'b0010111,
    OpBranch = 7'b1100011,
    OpJump   = 7'b1101111,
    OpLoad   = 7'b0000011,
    OpStore  = 7'b0100011
  } opcodeT;

  localparam funct7T Funct7Sub      = 7'b0100000;
  localparam funct7T Funct7Mul      = 7'b0000001;
  localparam funct7T Funct7AddOrAnd = 7'b0000000;

  localparam funct3T Funct3Add  = 3'b000;
  localparam funct3T Funct3Or   = 3'b110;
  localparam funct3T Funct3And  = 3'b111;
  localparam funct3T Funct3Addi = 3'b000;
  localparam funct3T Funct3Slli = 3'b001;
  localparam funct3T Funct3Srli = 3'b101;

  localparam funct3T Funct3Beq = 3'b000;
  localparam funct3T Funct3Bne = 3'b001;
  localparam funct3T Funct3Blt = 3'b100;
  localparam funct3T Funct3Bge = 3'b101;

  typedef struct packed {
    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    wordT   imm;   // already sign extended
  } decodedT;

endpackage

//--- verilog/rvSoc.sv
module rvSoc #(
  parameter int MemWords = 256
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               run,
  input  coreBusPkg::apbReqT hostReq,
  output coreBusPkg::apbRspT hostRsp,
  output logic               halted,
  output logic               busy
);

  coreBusPkg::apbReqT coreReq;
  coreBusPkg::apbRspT coreRsp;
  coreBusPkg::apbReqT ramReq;
  coreBusPkg::apbRspT ramRsp;

  coreControl core (
    .clk(clk), .arstN(arstN), .run(run),
    .busRsp(coreRsp), .busReq(coreReq),
    .halted(halted), .busy(busy)
  );

  // host and core are peer masters on the one RAM
  busArbiter arbiter (
    .clk(clk), .arstN(arstN),
    .hostReq(hostReq), .coreReq(coreReq), .ramRsp(ramRsp),
    .hostRsp(hostRsp), .coreRsp(coreRsp), .ramReq(ramReq)
  );

  apbRam #(
    .MemWords(MemWords)
  ) ram (
    .clk(clk), .arstN(arstN),
    .req(ramReq), .rsp(ramRsp)
  );

endmodule
